//--- hw/pdp8_pkg.sv
// Bits numbered 0 (MSB) to 11 as on the PDP-8; group 3 (MQ) and IOT encodings are not decoded
package pdp8_pkg;

	localparam int WORD_W = 12;                           // Word and address width

	localparam logic [0:2] OP_AND = 3'd0;                 // Logical AND into AC
	localparam logic [0:2] OP_TAD = 3'd1;                 // Two's complement add
	localparam logic [0:2] OP_ISZ = 3'd2;                 // Increment and skip on zero
	localparam logic [0:2] OP_DCA = 3'd3;                 // Deposit and clear AC
	localparam logic [0:2] OP_JMS = 3'd4;                 // Jump to subroutine
	localparam logic [0:2] OP_JMP = 3'd5;                 // Jump
	localparam logic [0:2] OP_IOT = 3'd6;                 // IO transfer, runs as no-op
	localparam logic [0:2] OP_OPR = 3'd7;                 // Operate microinstructions

	localparam logic [0:WORD_W-1] AUTO_INDEX_LO = 12'o0010; // First auto-index location
	localparam logic [0:WORD_W-1] AUTO_INDEX_HI = 12'o0017; // Last auto-index location

	// Group 1 microcode bits, numbered as in the instruction word
	localparam int G1_CLA   = 4;                          // Clear AC
	localparam int G1_CLL   = 5;                          // Clear link
	localparam int G1_CMA   = 6;                          // Complement AC
	localparam int G1_CML   = 7;                          // Complement link
	localparam int G1_RAR   = 8;                          // Rotate right
	localparam int G1_RAL   = 9;                          // Rotate left
	localparam int G1_TWICE = 10;                         // Rotate by two
	localparam int G1_IAC   = 11;                         // Increment AC

	// Group 2 microcode bits
	localparam int G2_CLA = 4;                            // Clear AC after skip test
	localparam int G2_SMA = 5;                            // SMA, or SPA when reversed
	localparam int G2_SZA = 6;                            // SZA, or SNA when reversed
	localparam int G2_SNL = 7;                            // SNL, or SZL when reversed
	localparam int G2_REV = 8;                            // Reverse skip sense
	localparam int G2_OSR = 9;                            // OR switch register into AC
	localparam int G2_HLT = 10;                           // Halt
	localparam int G2_G3  = 11;                           // Set selects group 3

	typedef union packed {
		struct packed {
			logic [0:2] opcode;
			logic       ind;                              // Indirect through the addressed word
			logic       page;                             // Current page when set, else page zero
			logic [0:6] offset;                           // Word within the page
		} mri;                                            // Memory-reference view
		struct packed {
			logic [0:2]  opcode;
			logic        grp;                             // Clear for group 1
			logic [4:11] ucode;                           // Microcode bits
		} opr;                                            // Operate view
	} pdp8_word_u;

endpackage

//--- hw/pdp8_memory.sv
// Read data lags the address by one cycle; contents power up undefined and are not reset
`timescale 1ns/1ns
module pdp8_memory #(
	parameter int MEM_DEPTH = 4096
) (
	input  logic                        clk,
	input  logic                        i_we,
	input  logic [0:pdp8_pkg::WORD_W-1] i_addr,
	input  logic [0:pdp8_pkg::WORD_W-1] i_wdata,
	output logic [0:pdp8_pkg::WORD_W-1] o_rdata
);
	import pdp8_pkg::*;

	logic [0:WORD_W-1] mem [0:MEM_DEPTH-1];               // Core array
	int unsigned       idx;                               // Word index after wrap

	assign idx = int'(i_addr) % MEM_DEPTH;                // Short memories alias upper addresses

	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[idx] <= i_wdata;                          // Write lands at this edge
		end
		o_rdata <= mem[idx];                              // Old data on a same-cycle write
	end

endmodule

//--- hw/pdp8_operate.sv
// Purely combinational; group 3 words pass AC and link unchanged, RAR wins over RAL
`timescale 1ns/1ns
module pdp8_operate (
	input  pdp8_pkg::pdp8_word_u        i_ir,
	input  logic [0:pdp8_pkg::WORD_W-1] i_ac,
	input  logic                        i_link,
	input  logic [0:pdp8_pkg::WORD_W-1] i_sr,
	output logic [0:pdp8_pkg::WORD_W-1] o_ac,
	output logic                        o_link,
	output logic                        o_skip,
	output logic                        o_halt
);
	import pdp8_pkg::*;

	logic [4:11]     uc;
	logic            grp1;
	logic            grp2;
	logic [0:WORD_W] lac;                                 // Link in bit 0, AC below it
	logic            any_cond;                            // Any selected SMA/SZA/SNL holds

	assign uc   = i_ir.opr.ucode;
	assign grp1 = (i_ir.opr.opcode == OP_OPR) && !i_ir.opr.grp;
	assign grp2 = (i_ir.opr.opcode == OP_OPR) && i_ir.opr.grp && !uc[G2_G3];

	// Tests see the AC and link from before any clear
	assign any_cond = (uc[G2_SMA] && i_ac[0])
	                || (uc[G2_SZA] && (i_ac == '0))
	                || (uc[G2_SNL] && i_link);

	always_comb begin
		lac = {i_link, i_ac};
		if (uc[G1_CLA]) begin
			lac[1:WORD_W] = '0;
		end
		if (uc[G1_CLL]) begin
			lac[0] = 1'b0;
		end
		if (uc[G1_CMA]) begin
			lac[1:WORD_W] = ~lac[1:WORD_W];
		end
		if (uc[G1_CML]) begin
			lac[0] = ~lac[0];
		end
		if (uc[G1_IAC]) begin
			lac = lac + 1'b1;                             // Carry out of AC flips link
		end
		if (uc[G1_RAR]) begin
			if (uc[G1_TWICE]) begin
				lac = {lac[WORD_W-1:WORD_W], lac[0:WORD_W-2]};
			end else begin
				lac = {lac[WORD_W], lac[0:WORD_W-1]};
			end
		end else if (uc[G1_RAL]) begin
			if (uc[G1_TWICE]) begin
				lac = {lac[2:WORD_W], lac[0:1]};
			end else begin
				lac = {lac[1:WORD_W], lac[0]};
			end
		end
	end

	always_comb begin
		o_ac   = i_ac;
		o_link = i_link;
		o_skip = 1'b0;
		o_halt = 1'b0;
		if (grp1) begin
			{o_link, o_ac} = lac;
		end else if (grp2) begin
			o_skip = uc[G2_REV] ? !any_cond : any_cond;   // Reversed with none selected is SKP
			if (uc[G2_CLA]) begin
				o_ac = '0;
			end
			if (uc[G2_OSR]) begin
				o_ac = o_ac | i_sr;
			end
			o_halt = uc[G2_HLT];
		end
	end

endmodule

//--- hw/pdp8_accumulator.sv
// Strobes are one-hot and take effect on the following edge; there is no MQ register
`timescale 1ns/1ns
module pdp8_accumulator (
	input  logic                        clk,
	input  logic                        i_arst_n,
	input  pdp8_pkg::pdp8_word_u        i_ir,
	input  logic [0:pdp8_pkg::WORD_W-1] i_mem_data,
	input  logic [0:pdp8_pkg::WORD_W-1] i_sr,
	input  logic                        i_do_and,
	input  logic                        i_do_tad,
	input  logic                        i_do_clear,
	input  logic                        i_do_operate,
	output logic [0:pdp8_pkg::WORD_W-1] o_ac,
	output logic                        o_link,
	output logic                        o_skip,
	output logic                        o_halt
);
	import pdp8_pkg::*;

	logic [0:WORD_W-1] opr_ac;                            // AC after microinstructions
	logic              opr_link;
	logic [0:WORD_W]   tad_sum;                           // Link and AC plus operand

	assign tad_sum = {o_link, o_ac} + {1'b0, i_mem_data}; // Carry out flips the link

	pdp8_operate u_operate (
		.i_ir   (i_ir),
		.i_ac   (o_ac),
		.i_link (o_link),
		.i_sr   (i_sr),
		.o_ac   (opr_ac),
		.o_link (opr_link),
		.o_skip (o_skip),
		.o_halt (o_halt)
	);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ac   <= '0;
			o_link <= 1'b0;
		end else if (i_do_and) begin
			o_ac <= o_ac & i_mem_data;
		end else if (i_do_tad) begin
			{o_link, o_ac} <= tad_sum;
		end else if (i_do_clear) begin
			o_ac <= '0;                                   // DCA after its write
		end else if (i_do_operate) begin
			o_ac   <= opr_ac;
			o_link <= opr_link;
		end
	end

endmodule

//--- hw/pdp8_sequencer.sv
// One instruction at a time; IOT is a no-op, group 3 is ignored, memory port free while halted
`timescale 1ns/1ns
module pdp8_sequencer (
	input  logic                        clk,
	input  logic                        i_arst_n,
	input  logic                        i_start,
	input  logic [0:pdp8_pkg::WORD_W-1] i_start_pc,
	input  logic [0:pdp8_pkg::WORD_W-1] i_mem_rdata,
	input  logic                        i_skip,
	input  logic                        i_halt,
	input  logic [0:pdp8_pkg::WORD_W-1] i_ac,
	output logic [0:pdp8_pkg::WORD_W-1] o_mem_addr,
	output logic                        o_mem_we,
	output logic [0:pdp8_pkg::WORD_W-1] o_mem_wdata,
	output pdp8_pkg::pdp8_word_u        o_ir,
	output logic                        o_do_and,
	output logic                        o_do_tad,
	output logic                        o_do_clear,
	output logic                        o_do_operate,
	output logic [0:pdp8_pkg::WORD_W-1] o_pc,
	output logic                        o_halted
);
	import pdp8_pkg::*;

	localparam logic [3:0] S_IDLE     = 4'd0;             // Out of reset, waiting for start
	localparam logic [3:0] S_FETCH    = 4'd1;             // PC on the address bus
	localparam logic [3:0] S_DECODE   = 4'd2;             // Instruction on the data bus
	localparam logic [3:0] S_DEFER_RD = 4'd3;             // Pointer address on the bus
	localparam logic [3:0] S_DEFER    = 4'd4;             // Pointer on the data bus
	localparam logic [3:0] S_AUTO_WR  = 4'd5;             // Incremented pointer written back
	localparam logic [3:0] S_EXEC_RD  = 4'd6;             // Operand address on the bus
	localparam logic [3:0] S_EXEC     = 4'd7;             // Operand on the data bus
	localparam logic [3:0] S_EXEC_WR  = 4'd8;             // DCA, JMS or ISZ write
	localparam logic [3:0] S_HALT     = 4'd9;             // Stopped by HLT

	localparam logic [0:WORD_W-1] ONE = 12'd1;
	localparam logic [0:WORD_W-1] TWO = 12'd2;

	logic [3:0]        state;
	logic [3:0]        exec_next;                         // State once the address is resolved
	logic [0:WORD_W-1] pc_q;
	logic [0:WORD_W-1] ea_q;                              // Effective address
	logic [0:WORD_W-1] mb_q;                              // Incremented memory data
	logic [0:WORD_W-1] ea_dir;                            // Address straight from the instruction
	logic [0:WORD_W-1] ea_res;                            // Address as resolved this cycle
	pdp8_word_u        ir_q;
	pdp8_word_u        cur_ir;
	logic [0:2]        op;
	logic              auto_idx;
	logic              jmp_op;

	// The instruction is only on the data bus during decode
	assign cur_ir = (state == S_DECODE) ? pdp8_word_u'(i_mem_rdata) : ir_q;
	assign op     = cur_ir.mri.opcode;
	assign jmp_op = (op == OP_JMP);

	assign ea_dir = cur_ir.mri.page ? {pc_q[0:4], cur_ir.mri.offset}
	                                : {5'b00000, cur_ir.mri.offset};
	assign auto_idx = (ea_q >= AUTO_INDEX_LO) && (ea_q <= AUTO_INDEX_HI); // Checked in defer

	always_comb begin
		case (state)
			S_DEFER:   ea_res = i_mem_rdata;                // Plain pointer used as is
			S_AUTO_WR: ea_res = mb_q;                       // Pointer after increment
			default:   ea_res = ea_dir;
		endcase
	end

	always_comb begin
		case (op)
			OP_AND, OP_TAD, OP_ISZ: exec_next = S_EXEC_RD;
			OP_DCA, OP_JMS:         exec_next = S_EXEC_WR;
			default:                exec_next = S_FETCH;    // JMP done once address is known
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= S_IDLE;
			pc_q  <= '0;
		end else begin
			case (state)
				S_IDLE, S_HALT: begin
					if (i_start) begin
						pc_q  <= i_start_pc;
						state <= S_FETCH;
					end
				end
				S_FETCH: state <= S_DECODE;
				S_DECODE: begin
					pc_q <= pc_q + ONE;                     // Return address for JMS too
					if (op == OP_OPR) begin
						if (i_skip) begin
							pc_q <= pc_q + TWO;
						end
						state <= i_halt ? S_HALT : S_FETCH;
					end else if (op == OP_IOT) begin
						state <= S_FETCH;
					end else if (cur_ir.mri.ind) begin
						state <= S_DEFER_RD;
					end else begin
						state <= exec_next;
						if (jmp_op) begin
							pc_q <= ea_res;
						end
					end
				end
				S_DEFER_RD: state <= S_DEFER;
				S_DEFER: begin
					if (auto_idx) begin
						state <= S_AUTO_WR;
					end else begin
						state <= exec_next;
						if (jmp_op) begin
							pc_q <= ea_res;
						end
					end
				end
				S_AUTO_WR: begin
					state <= exec_next;
					if (jmp_op) begin
						pc_q <= ea_res;
					end
				end
				S_EXEC_RD: state <= S_EXEC;
				S_EXEC:    state <= (op == OP_ISZ) ? S_EXEC_WR : S_FETCH;
				S_EXEC_WR: begin
					state <= S_FETCH;
					if (op == OP_ISZ && mb_q == '0) begin
						pc_q <= pc_q + ONE;                 // ISZ wrapped to zero
					end
					if (op == OP_JMS) begin
						pc_q <= ea_q + ONE;                 // Body starts after the entry word
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_DECODE) begin
			ir_q <= cur_ir;
		end
		// Keep the index location in ea_q until its write-back
		if (state == S_DECODE || state == S_AUTO_WR || (state == S_DEFER && !auto_idx)) begin
			ea_q <= ea_res;
		end
		if (state == S_DEFER || state == S_EXEC) begin
			mb_q <= i_mem_rdata + ONE;
		end
	end

	always_comb begin
		o_mem_wdata = mb_q;                               // ISZ and auto-index
		if (state == S_EXEC_WR && op == OP_DCA) begin
			o_mem_wdata = i_ac;
		end else if (state == S_EXEC_WR && op == OP_JMS) begin
			o_mem_wdata = pc_q;                           // Already one past the JMS
		end
	end

	assign o_mem_addr   = (state == S_FETCH) ? pc_q : ea_q;
	assign o_mem_we     = (state == S_AUTO_WR) || (state == S_EXEC_WR);
	assign o_ir         = cur_ir;
	assign o_do_and     = (state == S_EXEC) && (op == OP_AND);
	assign o_do_tad     = (state == S_EXEC) && (op == OP_TAD);
	assign o_do_clear   = (state == S_EXEC_WR) && (op == OP_DCA);
	assign o_do_operate = (state == S_DECODE) && (op == OP_OPR);
	assign o_pc         = pc_q;
	assign o_halted     = (state == S_IDLE) || (state == S_HALT);

endmodule

//--- hw/pdp8_top.sv
// Loader owns the memory port only while halted; start is ignored while a program runs
`timescale 1ns/1ns
module pdp8_top #(
	parameter int MEM_DEPTH = 4096
) (
	input  logic                        clk,
	input  logic                        i_arst_n,
	input  logic                        i_load_valid,
	input  logic [0:pdp8_pkg::WORD_W-1] i_load_addr,
	input  logic [0:pdp8_pkg::WORD_W-1] i_load_data,
	input  logic                        i_start,
	input  logic [0:pdp8_pkg::WORD_W-1] i_start_pc,
	input  logic [0:pdp8_pkg::WORD_W-1] i_sr,
	output logic                        o_load_ready,
	output logic [0:pdp8_pkg::WORD_W-1] o_ac,
	output logic                        o_link,
	output logic [0:pdp8_pkg::WORD_W-1] o_pc,
	output logic                        o_halted
);
	import pdp8_pkg::*;

	logic [0:WORD_W-1] seq_mem_addr;                      // Processor side of memory
	logic              seq_mem_we;
	logic [0:WORD_W-1] seq_mem_wdata;
	logic [0:WORD_W-1] mem_addr;                          // After the loader mux
	logic              mem_we;
	logic [0:WORD_W-1] mem_wdata;
	logic [0:WORD_W-1] mem_rdata;
	pdp8_word_u        ir;
	logic              do_and;
	logic              do_tad;
	logic              do_clear;
	logic              do_operate;
	logic              skip;
	logic              halt;
	logic [0:WORD_W-1] ac_zero_write;                     // AC as stored by DCA

	assign o_load_ready = o_halted;
	assign mem_addr     = o_halted ? i_load_addr : seq_mem_addr;
	assign mem_we       = o_halted ? (i_load_valid && o_load_ready) : seq_mem_we;
	assign mem_wdata    = o_halted ? i_load_data : seq_mem_wdata;
	assign o_ac         = ac_zero_write;

	pdp8_memory #(
		.MEM_DEPTH (MEM_DEPTH)
	) u_memory (
		.clk     (clk),
		.i_we    (mem_we),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.o_rdata (mem_rdata)
	);

	pdp8_sequencer u_sequencer (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_start      (i_start),
		.i_start_pc   (i_start_pc),
		.i_mem_rdata  (mem_rdata),
		.i_skip       (skip),
		.i_halt       (halt),
		.i_ac         (ac_zero_write),
		.o_mem_addr   (seq_mem_addr),
		.o_mem_we     (seq_mem_we),
		.o_mem_wdata  (seq_mem_wdata),
		.o_ir         (ir),
		.o_do_and     (do_and),
		.o_do_tad     (do_tad),
		.o_do_clear   (do_clear),
		.o_do_operate (do_operate),
		.o_pc         (o_pc),
		.o_halted     (o_halted)
	);

	pdp8_accumulator u_accumulator (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_ir         (ir),
		.i_mem_data   (mem_rdata),
		.i_sr         (i_sr),
		.i_do_and     (do_and),
		.i_do_tad     (do_tad),
		.i_do_clear   (do_clear),
		.i_do_operate (do_operate),
		.o_ac         (ac_zero_write),
		.o_link       (o_link),
		.o_skip       (skip),
		.o_halt       (halt)
	);

endmodule

//--- verification/pdp8_chk.sv
// Bound into pdp8_top; all properties are off while reset is asserted
`timescale 1ns/1ns
module pdp8_chk (
	input logic        clk,
	input logic        i_arst_n,
	input logic        i_start,
	input logic        i_load_ready,
	input logic        i_halted,
	input logic [11:0] i_pc,
	input logic        i_seq_we
);

	// Loader port closes once a start is taken
	start_closes_loader: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_start && i_halted |=> !i_load_ready)
		else $error("o_load_ready still high after start was accepted");

	pc_stable_when_halted: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_halted && $past(i_halted) |-> $stable(i_pc))
		else $error("o_pc moved while halted");

	// Halted memory writes can only come from the loader side of the mux
	no_seq_write_when_halted: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_halted |-> !i_seq_we)
		else $error("Processor memory write while halted");

endmodule

bind pdp8_top pdp8_chk u_chk (
	.clk          (clk),
	.i_arst_n     (i_arst_n),
	.i_start      (i_start),
	.i_load_ready (o_load_ready),
	.i_halted     (o_halted),
	.i_pc         (o_pc),
	.i_seq_we     (seq_mem_we)
);

//--- verification/pdp8_tb.sv
// Each test loads every word its program reads; memory contents outside those words never matter
`timescale 1ns/1ns
module pdp8_tb;

	localparam logic [2:0]  AND_OP  = 3'd0;
	localparam logic [2:0]  TAD_OP  = 3'd1;
	localparam logic [2:0]  ISZ_OP  = 3'd2;
	localparam logic [2:0]  DCA_OP  = 3'd3;
	localparam logic [2:0]  JMS_OP  = 3'd4;
	localparam logic [2:0]  JMP_OP  = 3'd5;
	localparam logic [11:0] CLA_CLL = 12'o7300;
	localparam logic [11:0] CML_W   = 12'o7020;
	localparam logic [11:0] NOP_W   = 12'o7000;
	localparam logic [11:0] IAC_W   = 12'o7001;
	localparam logic [11:0] HLT_W   = 12'o7402;
	localparam logic [11:0] ROTATES [5] = '{12'o0000, 12'o0010, 12'o0004, 12'o0012, 12'o0006};

	localparam int WORST_INSTR  = 8;                      // ISZ I through an auto-index word
	localparam int LONGEST_PROG = 9;                      // Instructions run by the DCA/ISZ program
	localparam int RUNS         = 4 + 2 + 3 + 1 + 160 + 98;
	localparam int RUN_LIMIT    = RUNS * LONGEST_PROG * WORST_INSTR + 1000;

	logic        clk;
	logic        i_arst_n;
	logic        i_load_valid;
	logic [11:0] i_load_addr;
	logic [11:0] i_load_data;
	logic        i_start;
	logic [11:0] i_start_pc;
	logic [11:0] i_sr;
	logic        o_load_ready;
	logic [11:0] o_ac;
	logic        o_link;
	logic [11:0] o_pc;
	logic        o_halted;
	logic [31:0] rng = 32'd75;                            // xorshift state
	logic [11:0] prog[$];                                 // Words for the next block load
	int          run_cycles = 0;

	pdp8_top #(
		.MEM_DEPTH (4096)
	) uut (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_load_valid (i_load_valid),
		.i_load_addr  (i_load_addr),
		.i_load_data  (i_load_data),
		.i_start      (i_start),
		.i_start_pc   (i_start_pc),
		.i_sr         (i_sr),
		.o_load_ready (o_load_ready),
		.o_ac         (o_ac),
		.o_link       (o_link),
		.o_pc         (o_pc),
		.o_halted     (o_halted)
	);

	always #20 clk = ~clk;                                // 40 ns period

	// Counts only cycles where a program is running
	always @(negedge clk) begin
		if (!o_halted) begin
			run_cycles = run_cycles + 1;
		end
		if (run_cycles > RUN_LIMIT) begin
			$display("Timeout: the processor ran %0d cycles and the run hung", run_cycles);
			$display("** FAIL **");
			$fatal(1, "Cycle limit reached");
		end
	end

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [11:0] rand12();
		rng = xorshift(rng);
		return rng[11:0];
	endfunction

	// Memory-reference word from opcode, I bit, page bit and target address
	function automatic logic [11:0] mri(logic [2:0] op, logic ind, logic cur, logic [11:0] addr);
		return {op, ind, cur, addr[6:0]};
	endfunction

	// Carry out of the AC complements the link
	function automatic logic [12:0] add_lac(logic [12:0] lac, logic [11:0] val);
		logic [12:0] sum;
		sum = {1'b0, lac[11:0]} + {1'b0, val};            // AC plus operand with its carry
		return {lac[12] ^ sum[12], sum[11:0]};
	endfunction

	function automatic logic [12:0] group1_model(logic [11:0] w, logic link, logic [11:0] ac);
		logic [12:0] lac;
		int          n;
		lac = {link, ac};
		if (w[7]) lac[11:0] = '0;                         // CLA
		if (w[6]) lac[12] = 1'b0;                         // CLL
		if (w[5]) lac[11:0] = ~lac[11:0];                 // CMA
		if (w[4]) lac[12] = ~lac[12];                     // CML
		if (w[0]) lac = lac + 13'd1;                      // IAC
		n = w[1] ? 2 : 1;
		for (int i = 0; i < n; i++) begin
			if (w[3]) begin
				lac = {lac[0], lac[12:1]};                // AC bit 11 into link
			end else if (w[2]) begin
				lac = {lac[11:0], lac[12]};
			end
		end
		return lac;
	endfunction

	function automatic logic skip_model(logic [11:0] w, logic link, logic [11:0] ac);
		if (w[3]) begin
			return (!w[6] || !ac[11]) && (!w[5] || ac != 12'd0) && (!w[4] || !link);
		end
		return (w[6] && ac[11]) || (w[5] && ac == 12'd0) || (w[4] && link);
	endfunction

	task automatic check(string name, logic [12:0] expected, logic [12:0] actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %o, got %o", $time, name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic expect_result(logic [12:0] lac, logic [11:0] pc);
		check("o_ac", {1'b0, lac[11:0]}, {1'b0, o_ac});
		check("o_link", {12'd0, lac[12]}, {12'd0, o_link});
		check("o_pc", {1'b0, pc}, {1'b0, o_pc});
	endtask

	task automatic load_word(logic [11:0] addr, logic [11:0] data);
		@(posedge clk);
		i_load_valid <= 1'b1;
		i_load_addr  <= addr;
		i_load_data  <= data;
		@(negedge clk);
		while (!o_load_ready) @(negedge clk);             // Hold until the port opens
		@(posedge clk);                                   // Handshake edge
		i_load_valid <= 1'b0;
	endtask

	task automatic load_block(logic [11:0] base);
		foreach (prog[i]) begin
			load_word(base + 12'(i), prog[i]);
		end
	endtask

	task automatic run_program(logic [11:0] pc, logic [11:0] sr);
		@(posedge clk);
		i_start    <= 1'b1;
		i_start_pc <= pc;
		i_sr       <= sr;
		@(posedge clk);
		i_start <= 1'b0;
		@(negedge clk);
		check("o_halted", 13'd0, {12'd0, o_halted});      // Start was taken
		while (!o_halted) @(negedge clk);
	endtask

	task automatic test_and_tad(logic link_in, logic [11:0] a, logic [11:0] m, logic [11:0] b);
		prog = {link_in ? 12'o7320 : CLA_CLL, mri(TAD_OP, 1'b0, 1'b0, 12'o0050),
		        mri(AND_OP, 1'b0, 1'b1, 12'o0220), mri(TAD_OP, 1'b0, 1'b1, 12'o0221), HLT_W};
		load_block(12'o0200);
		load_word(12'o0050, a);                           // Page zero operand
		prog = {m, b};                                    // Current page operands
		load_block(12'o0220);
		run_program(12'o0200, 12'd0);
		expect_result(add_lac({link_in, a & m}, b), 12'o0205);
	endtask

	task automatic test_dca_isz(logic [11:0] v, logic [11:0] w);
		logic [12:0] lac;
		prog = {CLA_CLL, mri(TAD_OP, 1'b0, 1'b0, 12'o0060), mri(DCA_OP, 1'b0, 1'b0, 12'o0061),
		        mri(TAD_OP, 1'b0, 1'b0, 12'o0061), mri(ISZ_OP, 1'b0, 1'b0, 12'o0062), IAC_W,
		        mri(ISZ_OP, 1'b0, 1'b0, 12'o0063), IAC_W, mri(TAD_OP, 1'b0, 1'b0, 12'o0063), HLT_W};
		load_block(12'o0400);
		prog = {v, 12'o5555, 12'o7777, w};                // 7777 wraps and skips
		load_block(12'o0060);
		run_program(12'o0400, 12'd0);
		lac = add_lac({1'b0, v}, 12'd1);                  // Only the second IAC runs
		lac = add_lac(lac, w + 12'd1);
		expect_result(lac, 12'o0412);
	endtask

	task automatic test_indirect();
		logic [11:0] d1;
		logic [11:0] d2;
		logic [11:0] d3;
		d1 = rand12();
		d2 = rand12();
		d3 = rand12();
		prog = {CLA_CLL, mri(TAD_OP, 1'b1, 1'b0, 12'o0012), mri(TAD_OP, 1'b1, 1'b0, 12'o0012),
		        mri(TAD_OP, 1'b1, 1'b0, 12'o0070), HLT_W,
		        CLA_CLL, mri(TAD_OP, 1'b0, 1'b0, 12'o0012), HLT_W,
		        CLA_CLL, mri(TAD_OP, 1'b0, 1'b0, 12'o0070), HLT_W};
		load_block(12'o0600);
		load_word(12'o0012, 12'o2000);                    // Auto-index pointer
		load_word(12'o0070, 12'o2100);                    // Plain pointer
		prog = {12'o7070, d1, d2};                        // Word at the pointer itself is a decoy
		load_block(12'o2000);
		prog = {d3, 12'o0707};
		load_block(12'o2100);
		run_program(12'o0600, 12'd0);
		expect_result(add_lac(add_lac(add_lac(13'd0, d1), d2), d3), 12'o0605);
		run_program(12'o0605, 12'd0);
		expect_result({1'b0, 12'o2002}, 12'o0610);        // Pointer advanced twice
		run_program(12'o0610, 12'd0);
		expect_result({1'b0, 12'o2100}, 12'o0613);
	endtask

	task automatic test_jms_jmp(logic [11:0] x, logic [11:0] y);
		prog = {CLA_CLL, mri(JMS_OP, 1'b0, 1'b1, 12'o1210), mri(TAD_OP, 1'b0, 1'b1, 12'o1220),
		        mri(TAD_OP, 1'b0, 1'b1, 12'o1210), mri(JMP_OP, 1'b0, 1'b1, 12'o1206), IAC_W, HLT_W};
		load_block(12'o1200);
		prog = {12'o0000, mri(TAD_OP, 1'b0, 1'b1, 12'o1221), mri(JMP_OP, 1'b1, 1'b1, 12'o1210)};
		load_block(12'o1210);                             // Subroutine with its entry word
		prog = {x, y};
		load_block(12'o1220);
		run_program(12'o1200, 12'd0);
		expect_result(add_lac(add_lac(add_lac(13'd0, y), x), 12'o1202), 12'o1207);
	endtask

	task automatic test_group1(logic [11:0] ucode, logic [11:0] ac, logic link);
		prog = {CLA_CLL, mri(TAD_OP, 1'b0, 1'b1, 12'o1420), link ? CML_W : NOP_W,
		        12'o7000 | ucode, HLT_W};
		load_block(12'o1400);
		load_word(12'o1420, ac);
		run_program(12'o1400, 12'd0);
		expect_result(group1_model(ucode, link, ac), 12'o1405);
	endtask

	task automatic test_group2(logic [11:0] ucode, logic [11:0] ac, logic link, logic [11:0] sr);
		logic [12:0] lac;
		prog = {CLA_CLL, mri(TAD_OP, 1'b0, 1'b1, 12'o1620), link ? CML_W : NOP_W,
		        12'o7400 | ucode, IAC_W, HLT_W};
		load_block(12'o1600);
		load_word(12'o1620, ac);
		run_program(12'o1600, sr);
		lac = {link, ac};
		if (ucode[7]) lac[11:0] = '0;                     // CLA after the skip test
		if (ucode[2]) lac[11:0] = lac[11:0] | sr;         // OSR
		if (!skip_model(ucode, link, ac)) lac = add_lac(lac, 12'd1);
		expect_result(lac, 12'o1606);
	endtask

	initial begin
		logic [11:0] r12;
		logic [11:0] ac_val;
		clk          = 1'b0;
		i_arst_n     = 1'b0;
		i_load_valid = 1'b0;
		i_load_addr  = '0;
		i_load_data  = '0;
		i_start      = 1'b0;
		i_start_pc   = '0;
		i_sr         = '0;
		repeat (8) @(posedge clk);
		i_arst_n <= 1'b1;
		@(negedge clk);
		check("o_halted", 13'd1, {12'd0, o_halted});
		check("o_load_ready", 13'd1, {12'd0, o_load_ready});
		expect_result(13'd0, 12'd0);

		test_and_tad(1'b0, 12'o7070, 12'o7707, 12'o0123);
		test_and_tad(1'b0, 12'o6543, 12'o7770, 12'o2000); // Carry sets the link
		test_and_tad(1'b1, 12'o6543, 12'o7770, 12'o2000); // Carry clears it again
		test_and_tad(1'b1, rand12(), rand12(), rand12());
		test_dca_isz(rand12(), rand12() & 12'o3777);
		test_dca_isz(rand12(), rand12() & 12'o3777);
		test_indirect();
		test_jms_jmp(rand12(), rand12());

		// CLA, CLL, CMA, CML and IAC in every mix, against each rotate
		for (int c = 0; c < 32; c++) begin
			for (int r = 0; r < 5; r++) begin
				r12 = rand12();
				test_group1({4'b0000, c[4:1], 3'b000, c[0]} | ROTATES[r], rand12(), r12[0]);
			end
		end

		for (int k = 0; k < 3; k++) begin
			for (int l = 0; l < 2; l++) begin
				for (int s = 0; s < 16; s++) begin
					r12 = rand12();
					ac_val = (k == 0) ? 12'o0000 :
					         (k == 1) ? (r12 | 12'o4000) : ((r12 & 12'o3777) | 12'o0001);
					test_group2({5'b00000, s[3:0], 3'b000}, ac_val, l[0], 12'd0);
				end
			end
		end
		test_group2(12'o0004, rand12(), 1'b0, rand12());  // OSR
		test_group2(12'o0204, rand12(), 1'b1, rand12());  // CLA OSR

		$display("** PASS **");
		$finish;
	end

endmodule

//--- all.f
hw/pdp8_pkg.sv
hw/pdp8_memory.sv
hw/pdp8_operate.sv
hw/pdp8_accumulator.sv
hw/pdp8_sequencer.sv
hw/pdp8_top.sv
verification/pdp8_chk.sv
verification/pdp8_tb.sv

//--- Makefile
TOP := pdp8_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then exit 1; fi
	@grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log
